// ==== hw/route_pkg.sv ====
`default_nettype none

package route_pkg;

	// data types
	typedef logic [15:0] word_t;      // raw word from memory
	typedef logic [15:0] fix_t;       // 11.5 fixed point
	typedef logic [15:0] batt_t;      // 1.15 battery fraction
	typedef logic [10:0] byte_addr_t; // byte address, 2 KiB space
	typedef logic [7:0]  mem_byte_t;

	// memory map
	localparam int         MEM_DEPTH           = 2048;
	localparam byte_addr_t NEIGHBOR_COUNT_ADDR = 11'h68A;
	localparam byte_addr_t Q_TABLE_ADDR        = 11'h1C8; // q entry 0
	localparam byte_addr_t HCM_TABLE_ADDR      = 11'h648; // hcm entry 0

	// table sizes
	localparam int HCM_LENGTH    = 11;
	localparam int MAX_NEIGHBORS = 64; // larger counts get clamped

	// fixed point formats
	localparam int   FRAC_BITS      = 5;
	localparam int   BATT_FRAC_BITS = 15;
	localparam fix_t MYBEST_INIT    = 16'hFFFE;

	// engine FSM
	typedef enum logic [3:0] {
		IDLE,
		REQ_COUNT,
		WAIT_COUNT,
		REQ_Q,
		WAIT_Q,
		HCM_INDEX,
		REQ_HCM,
		WAIT_HCM,
		DONE
	} find_state_t;

endpackage

`default_nettype wire

// ==== hw/mem_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_rd_if;

	logic                   req_valid;
	logic                   req_ready;
	route_pkg::byte_addr_t  addr;      // held while stalled
	logic                   rsp_valid; // one cycle after the transfer
	route_pkg::word_t       rsp_data;  // {byte at addr+1, byte at addr}

	modport requester (
		output req_valid,
		output addr,
		input  req_ready,
		input  rsp_valid,
		input  rsp_data
	);

	modport memory (
		input  req_valid,
		input  addr,
		output req_ready,
		output rsp_valid,
		output rsp_data
	);

endinterface

`default_nettype wire

// ==== hw/node_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module node_mem (
	input  wire logic                  clock,
	input  wire logic                  nrst,
	input  wire logic                  wr_en,
	input  wire route_pkg::byte_addr_t wr_addr,
	input  wire route_pkg::mem_byte_t  wr_data,
	mem_rd_if.memory                   rd
);

	route_pkg::mem_byte_t  mem [route_pkg::MEM_DEPTH];
	route_pkg::byte_addr_t addr_hi; // second byte of the word
	logic                  rd_fire;
	logic                  rsp_valid_q;
	route_pkg::word_t      rsp_data_q;

	// external writes win and the engine read waits a cycle
	assign rd.req_ready = ~wr_en;
	assign rd_fire      = rd.req_valid & rd.req_ready;

	// 11-bit add wraps at the top of the array
	assign addr_hi = rd.addr + 11'd1;

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// little-endian word, registered
	always_ff @(posedge clock) begin
		if (rd_fire) begin
			rsp_data_q <= {mem[addr_hi], mem[rd.addr]};
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= rd_fire; // one response per accepted request
		end
	end

	assign rd.rsp_valid = rsp_valid_q;
	assign rd.rsp_data  = rsp_data_q;

	// only one read in flight, so responses never come back to back
	a_rsp_single : assert property (
		@(posedge clock) disable iff (!nrst)
		rd.rsp_valid |=> !rd.rsp_valid
	);

endmodule

`default_nettype wire

// ==== hw/find_my_best.sv ====
`timescale 1ns/1ps
`default_nettype none

module find_my_best (
	input  wire logic             clock,
	input  wire logic             nrst,
	input  wire logic             start,
	input  wire route_pkg::batt_t battery,
	mem_rd_if.requester           rd,
	output logic                  busy,
	output logic                  done,
	output route_pkg::fix_t       my_best
);

	route_pkg::find_state_t state;

	logic            accept;      // start taken this cycle
	route_pkg::batt_t batt_q;     // battery sampled at start
	route_pkg::fix_t min_q;       // running minimum of q
	route_pkg::fix_t my_best_q;
	logic [6:0]      nbr_cnt;     // 0..64 after clamp
	logic [6:0]      cnt_clamped;
	logic [6:0]      q_idx;
	logic [6:0]      q_idx_nxt;
	logic [3:0]      hcm_idx;     // 0..10
	logic [19:0]     k_prod;      // 10 * battery, 5.15
	logic [4:0]      k_ceil;      // up to 20 before clamp
	logic [31:0]     prod;        // 22.10 product

	assign accept = start & ((state == route_pkg::IDLE) | (state == route_pkg::DONE));

	assign cnt_clamped = (rd.rsp_data > route_pkg::word_t'(route_pkg::MAX_NEIGHBORS)) ?
		7'(route_pkg::MAX_NEIGHBORS) : rd.rsp_data[6:0];

	assign q_idx_nxt = q_idx + 7'd1;

	// ceiling of 10 * battery with the 15 fraction bits dropped
	assign k_prod = batt_q * 20'(route_pkg::HCM_LENGTH - 1);
	assign k_ceil = k_prod[19:route_pkg::BATT_FRAC_BITS]
		+ 5'(|k_prod[route_pkg::BATT_FRAC_BITS-1:0]);

	// 11.5 * 11.5 -> keep the 11.5 slice
	assign prod = min_q * rd.rsp_data;

	// held for the index step
	always_ff @(posedge clock) begin
		if (accept) begin
			batt_q <= battery;
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state     <= route_pkg::IDLE;
			min_q     <= route_pkg::MYBEST_INIT;
			my_best_q <= route_pkg::MYBEST_INIT;
			nbr_cnt   <= '0;
			q_idx     <= '0;
			hcm_idx   <= '0;
		end else begin
			case (state)
				route_pkg::IDLE, route_pkg::DONE: begin
					if (accept) begin
						min_q <= route_pkg::MYBEST_INIT;
						q_idx <= '0;
						state <= route_pkg::REQ_COUNT;
					end else begin
						state <= route_pkg::IDLE;
					end
				end

				route_pkg::REQ_COUNT: begin
					if (rd.req_ready) begin
						state <= route_pkg::WAIT_COUNT;
					end
				end

				route_pkg::WAIT_COUNT: begin
					if (rd.rsp_valid) begin
						nbr_cnt <= cnt_clamped;
						// min stays at init without neighbors
						if (cnt_clamped == 7'd0) begin
							state <= route_pkg::HCM_INDEX;
						end else begin
							state <= route_pkg::REQ_Q;
						end
					end
				end

				route_pkg::REQ_Q: begin
					if (rd.req_ready) begin
						state <= route_pkg::WAIT_Q;
					end
				end

				route_pkg::WAIT_Q: begin
					if (rd.rsp_valid) begin
						if (rd.rsp_data < min_q) begin // unsigned compare
							min_q <= rd.rsp_data;
						end
						q_idx <= q_idx_nxt;
						if (q_idx_nxt == nbr_cnt) begin
							state <= route_pkg::HCM_INDEX;
						end else begin
							state <= route_pkg::REQ_Q;
						end
					end
				end

				route_pkg::HCM_INDEX: begin
					if (k_ceil > 5'(route_pkg::HCM_LENGTH - 1)) begin
						hcm_idx <= 4'(route_pkg::HCM_LENGTH - 1);
					end else begin
						hcm_idx <= k_ceil[3:0];
					end
					state <= route_pkg::REQ_HCM;
				end

				route_pkg::REQ_HCM: begin
					if (rd.req_ready) begin
						state <= route_pkg::WAIT_HCM;
					end
				end

				route_pkg::WAIT_HCM: begin
					if (rd.rsp_valid) begin
						my_best_q <= prod[15+route_pkg::FRAC_BITS:route_pkg::FRAC_BITS];
						state     <= route_pkg::DONE;
					end
				end

				default: begin
					state <= route_pkg::IDLE;
				end
			endcase
		end
	end

	// read request side of the handshake
	always_comb begin
		rd.req_valid = 1'b0;
		rd.addr      = route_pkg::NEIGHBOR_COUNT_ADDR;
		case (state)
			route_pkg::REQ_COUNT: begin
				rd.req_valid = 1'b1;
			end
			route_pkg::REQ_Q: begin
				rd.req_valid = 1'b1;
				rd.addr      = route_pkg::Q_TABLE_ADDR + route_pkg::byte_addr_t'({q_idx, 1'b0});
			end
			route_pkg::REQ_HCM: begin
				rd.req_valid = 1'b1;
				rd.addr      = route_pkg::HCM_TABLE_ADDR
					+ route_pkg::byte_addr_t'({hcm_idx, 1'b0});
			end
			default: begin
				rd.req_valid = 1'b0;
			end
		endcase
	end

	assign busy    = (state != route_pkg::IDLE) & (state != route_pkg::DONE);
	assign done    = (state == route_pkg::DONE); // busy drops in the same cycle
	assign my_best = my_best_q;

	// a stalled request keeps its address until the memory takes it
	a_addr_stable : assert property (
		@(posedge clock) disable iff (!nrst)
		(rd.req_valid && !rd.req_ready) |=> (rd.req_valid && $stable(rd.addr))
	);

	// no read pending or still answering when the result is reported
	a_done_no_req : assert property (
		@(posedge clock) disable iff (!nrst)
		done |-> !(rd.req_valid || rd.rsp_valid)
	);

endmodule

`default_nettype wire

// ==== hw/route_select_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module route_select_top (
	input  wire logic                  clock,
	input  wire logic                  nrst,

	// external memory load port
	input  wire logic                  wr_en,
	input  wire route_pkg::byte_addr_t wr_addr,
	input  wire route_pkg::mem_byte_t  wr_data,

	// engine control
	input  wire logic                  start,
	input  wire route_pkg::batt_t      battery,

	// result
	output logic                       busy,
	output logic                       done,
	output route_pkg::fix_t            my_best
);

	// engine to memory word reads
	mem_rd_if rd_bus ();

	node_mem u_mem (
		.clock   (clock),
		.nrst    (nrst),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd      (rd_bus.memory)
	);

	find_my_best u_engine (
		.clock   (clock),
		.nrst    (nrst),
		.start   (start),
		.battery (battery),
		.rd      (rd_bus.requester),
		.busy    (busy),
		.done    (done),
		.my_best (my_best)
	);

endmodule

`default_nettype wire

// ==== dv/route_select_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module route_select_tb;

	localparam int CLK_HALF    = 2;
	localparam int CLK_PERIOD  = 2 * CLK_HALF;
	localparam int N_RANDOM    = 12;
	localparam int N_EDGE      = 12;
	localparam int N_TRIALS    = N_RANDOM + N_EDGE;
	localparam int LOAD_CYCLES = route_pkg::MEM_DEPTH + 4;
	localparam int WORST_LAT   = 2 + 2 + 2 * route_pkg::MAX_NEIGHBORS + 1 + 2 + 2;
	// stall writes never come back to back, so each access grows by one cycle at most
	localparam int TRIAL_CYCLES = LOAD_CYCLES + 2 * WORST_LAT + 8;
	localparam int WATCHDOG_NS  = 2 * N_TRIALS * TRIAL_CYCLES * CLK_PERIOD;

	logic                  clock;
	logic                  nrst;
	logic                  wr_en;
	route_pkg::byte_addr_t wr_addr;
	route_pkg::mem_byte_t  wr_data;
	logic                  start;
	route_pkg::batt_t      battery;
	logic                  busy;
	logic                  done;
	route_pkg::fix_t       my_best;

	route_pkg::mem_byte_t  image [route_pkg::MEM_DEPTH]; // copy of the node memory
	integer                seed;
	int                    err_count;
	int                    check_count;

	route_select_top UUT (
		.clock   (clock),
		.nrst    (nrst),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.start   (start),
		.battery (battery),
		.busy    (busy),
		.done    (done),
		.my_best (my_best)
	);

	always #CLK_HALF clock = ~clock;

	task automatic check_fix(input string what, input route_pkg::fix_t got,
		input route_pkg::fix_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("** Error at %0t ns: %s got %b, expected %b", $time, what, got, exp);
		end
	endtask

	// little-endian word from the copy, wrapping at the top
	function automatic route_pkg::word_t image_word(input route_pkg::byte_addr_t addr);
		return {image[addr + 11'd1], image[addr]};
	endfunction

	function automatic route_pkg::fix_t expected_best(input route_pkg::batt_t batt);
		route_pkg::word_t count;
		route_pkg::fix_t  best;
		route_pkg::word_t q;
		route_pkg::word_t hcm;
		logic [31:0]      product;
		int               n;
		int               i;
		int               tenths;
		int               k;
		count = image_word(route_pkg::NEIGHBOR_COUNT_ADDR);
		n = (count > 16'(route_pkg::MAX_NEIGHBORS)) ? route_pkg::MAX_NEIGHBORS : int'(count);
		best = route_pkg::MYBEST_INIT;
		for (i = 0; i < n; i++) begin
			q = image_word(route_pkg::Q_TABLE_ADDR + route_pkg::byte_addr_t'(2 * i));
			if (q < best) begin
				best = q;
			end
		end
		// ceiling of ten times the battery fraction
		tenths = int'(batt) * (route_pkg::HCM_LENGTH - 1);
		k = tenths / (1 << route_pkg::BATT_FRAC_BITS);
		if ((tenths % (1 << route_pkg::BATT_FRAC_BITS)) != 0) begin
			k++;
		end
		if (k > route_pkg::HCM_LENGTH - 1) begin
			k = route_pkg::HCM_LENGTH - 1;
		end
		hcm = image_word(route_pkg::HCM_TABLE_ADDR + route_pkg::byte_addr_t'(2 * k));
		product = 32'(best) * 32'(hcm);
		return route_pkg::fix_t'(product >> route_pkg::FRAC_BITS);
	endfunction

	// fresh random image with a chosen neighbor count, written byte by byte
	task automatic load_image(input route_pkg::word_t count);
		int i;
		for (i = 0; i < route_pkg::MEM_DEPTH; i++) begin
			image[route_pkg::byte_addr_t'(i)] = route_pkg::mem_byte_t'($random(seed));
		end
		image[route_pkg::NEIGHBOR_COUNT_ADDR]         = count[7:0];
		image[route_pkg::NEIGHBOR_COUNT_ADDR + 11'd1] = count[15:8];
		for (i = 0; i < route_pkg::MEM_DEPTH; i++) begin
			@(negedge clock);
			wr_en   = 1'b1;
			wr_addr = route_pkg::byte_addr_t'(i);
			wr_data = image[route_pkg::byte_addr_t'(i)];
		end
		@(negedge clock);
		wr_en = 1'b0;
	endtask

	task automatic run_trial(input string name, input route_pkg::batt_t batt,
		input bit stall, input bit restart);
		route_pkg::fix_t exp;
		logic            wrote;
		exp = expected_best(batt);
		@(negedge clock);
		start   = 1'b1;
		battery = batt;
		@(negedge clock);
		start   = 1'b0;
		battery = route_pkg::batt_t'($random(seed)); // sampled only at start
		check_bit({name, ": busy after start"}, busy, 1'b1);
		wrote = 1'b0;
		while (!done) begin
			// writes below the q table leave the model untouched
			wr_en = stall && !wrote && (($random(seed) & 1) != 0);
			if (wr_en) begin
				wr_addr = route_pkg::byte_addr_t'($unsigned($random(seed))
					% 32'(route_pkg::Q_TABLE_ADDR));
				wr_data = route_pkg::mem_byte_t'($random(seed));
				image[wr_addr] = wr_data;
			end
			wrote = wr_en;
			if (restart && busy && (($random(seed) & 3) == 0)) begin
				start   = 1'b1;
				battery = route_pkg::batt_t'($random(seed));
			end else begin
				start = 1'b0;
			end
			@(negedge clock);
		end
		wr_en = 1'b0;
		start = 1'b0;
		check_bit({name, ": busy with done"}, busy, 1'b0);
		@(negedge clock);
		check_bit({name, ": done one cycle"}, done, 1'b0);
		check_bit({name, ": idle after done"}, busy, 1'b0); // a late start was dropped
		check_fix({name, ": my_best"}, my_best, exp);
	endtask

	initial begin
		int t;
		seed        = 32'hbe7b52cc;
		err_count   = 0;
		check_count = 0;
		clock       = 1'b0;
		nrst        = 1'b0;
		wr_en       = 1'b0;
		wr_addr     = '0;
		wr_data     = '0;
		start       = 1'b0;
		battery     = '0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		nrst = 1'b1;

		check_bit("reset: busy", busy, 1'b0);
		check_bit("reset: done", done, 1'b0);
		check_fix("reset: my_best", my_best, route_pkg::MYBEST_INIT);

		for (t = 0; t < N_RANDOM; t++) begin
			load_image(route_pkg::word_t'(1 + ($unsigned($random(seed))
				% route_pkg::MAX_NEIGHBORS)));
			run_trial("random", route_pkg::batt_t'($random(seed)), (t % 3) == 2, 1'b0);
		end

		load_image(16'd0);
		run_trial("zero neighbors", route_pkg::batt_t'($random(seed)), 1'b0, 1'b0);
		load_image(16'd65);
		run_trial("count 65", route_pkg::batt_t'($random(seed)), 1'b0, 1'b0);
		load_image(16'hFFFF);
		run_trial("count ffff", route_pkg::batt_t'($random(seed)), 1'b0, 1'b0);

		// battery corners share one image
		load_image(route_pkg::word_t'(1 + ($unsigned($random(seed)) % 8)));
		run_trial("battery 0000", 16'h0000, 1'b0, 1'b0);
		run_trial("battery 7fff", 16'h7FFF, 1'b0, 1'b0);
		run_trial("battery ffff", 16'hFFFF, 1'b0, 1'b0);
		run_trial("battery 4000", 16'h4000, 1'b0, 1'b0); // exactly five tenths
		run_trial("battery 0ccd", 16'h0CCD, 1'b0, 1'b0); // just past one tenth

		load_image(route_pkg::word_t'(route_pkg::MAX_NEIGHBORS));
		run_trial("stalled full", route_pkg::batt_t'($random(seed)), 1'b1, 1'b0);
		run_trial("stalled again", route_pkg::batt_t'($random(seed)), 1'b1, 1'b0);
		load_image(16'd40);
		run_trial("second start", route_pkg::batt_t'($random(seed)), 1'b0, 1'b1);
		run_trial("stall and restart", route_pkg::batt_t'($random(seed)), 1'b1, 1'b1);

		$display("checks %0d, value errors %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// upper bound on the whole run, loads included
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the engine never signalled done within %0d ns", WATCHDOG_NS);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/route_pkg.sv
hw/mem_rd_if.sv
hw/node_mem.sv
hw/find_my_best.sv
hw/route_select_top.sv
dv/route_select_tb.sv

// ==== Makefile ====
# Verilator build and run for the route selection engine

VERILATOR  ?= verilator
TOP        ?= route_select_tb
FLIST      ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
FAIL_MSG   ?= tests failed
PASS_MSG   ?= all tests passed

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
